// File: Makefile
TOP := tb_stepper_drive

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

// File: all.f
src/motor_pkg.sv
src/drive_pkg.sv
src/step_sequencer.sv
src/current_chopper.sv
src/bridge_gate_ctrl.sv
src/hbridge_coil.sv
src/stepper_drive.sv
testbench/tb_stepper_drive.sv

// File: src/bridge_gate_ctrl.sv
// gate controller mapping a bridge mode to four gate levels with dead time on every change
`timescale 1ns/1ps

module bridge_gate_ctrl (
    input  logic                     clk,
    input  logic                     resetn,
    input  drive_pkg::bridge_mode_t  mode,
    input  logic                     polarity_invert_config,  // coil wired the other way round
    output logic                     low_1,
    output logic                     high_1,
    output logic                     low_2,
    output logic                     high_2
);
    import drive_pkg::*;

    bridge_mode_t applied_mode;    // mode whose gates are (or will be) shown
    logic         applied_invert;  // wiring that the gates were mapped with
    dead_cnt_t    dead_cnt;        // remaining all-off cycles
    logic         change;
    logic [3:0]   gates;           // {high_2, low_2, high_1, low_1}
    logic [3:0]   mode_gates;      // pattern for applied_mode

    assign change = (mode != applied_mode) || (polarity_invert_config != applied_invert);

    // inverted wiring swaps the two diagonal pairs
    always_comb begin
        case (applied_mode)
            MODE_POS:   mode_gates = applied_invert ? 4'b0110 : 4'b1001;
            MODE_NEG:   mode_gates = applied_invert ? 4'b1001 : 4'b0110;
            MODE_DECAY: mode_gates = 4'b0101;  // both lows on
            default:    mode_gates = 4'b0000;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            applied_mode   <= MODE_DECAY;
            applied_invert <= polarity_invert_config;  // strap taken during reset
            dead_cnt       <= '0;
            gates          <= '0;
        end else if (change) begin
            applied_mode   <= mode;
            applied_invert <= polarity_invert_config;
            dead_cnt       <= dead_cnt_t'(DEAD_CYCLES);  // first dead cycle starts now
            gates          <= '0;
        end else if (dead_cnt != '0) begin
            dead_cnt <= dead_cnt - 1'b1;
            if (dead_cnt == dead_cnt_t'(1))
                gates <= mode_gates;  // dead time over
        end
    end

    assign {high_2, low_2, high_1, low_1} = gates;

    // no shoot-through on either half bridge
    a_no_shoot_1: assert property (@(posedge clk) disable iff (!resetn) !(low_1 && high_1));
    a_no_shoot_2: assert property (@(posedge clk) disable iff (!resetn) !(low_2 && high_2));

endmodule

// File: src/current_chopper.sv
// current chopper: hysteresis comparator choosing the bridge mode for one coil
`timescale 1ns/1ps

module current_chopper (
    input  logic                      clk,
    input  logic                      resetn,
    input  motor_pkg::coil_current_t  target,            // wanted coil current
    input  motor_pkg::coil_current_t  current,           // modelled coil current
    input  logic                      current_positive,  // sign from the coil model
    output drive_pkg::bridge_mode_t   mode
);
    import motor_pkg::*;
    import drive_pkg::*;

    current_err_t err;        // target - current, sign extended
    bridge_mode_t want_mode;  // raw comparator decision
    bridge_mode_t next_mode;  // after the zero target rule
    logic         target_zero;

    assign target_zero = (target == '0);

    // error outside the band drives toward the target, inside it coasts
    always_comb begin
        err = current_err_t'(target) - current_err_t'(current);
        if (err > HYSTERESIS)
            want_mode = MODE_POS;       // current too low
        else if (err < -HYSTERESIS)
            want_mode = MODE_NEG;       // current too high
        else
            want_mode = MODE_DECAY;     // inside the dead band
    end

    // with a zero target never push against the current, just let it decay
    always_comb begin
        next_mode = want_mode;
        if (target_zero) begin
            if (want_mode == MODE_NEG && current_positive)
                next_mode = MODE_DECAY;  // would reverse a positive current
            if (want_mode == MODE_POS && !current_positive)
                next_mode = MODE_DECAY;  // would reverse a negative current
        end
    end

    // mode register, re-evaluated every cycle
    always_ff @(posedge clk) begin
        if (!resetn)
            mode <= MODE_DECAY;
        else
            mode <= next_mode;
    end

    // only the three defined encodings ever leave the chopper
    a_mode_legal: assert property (
        @(posedge clk) disable iff (!resetn)
        mode inside {MODE_DECAY, MODE_POS, MODE_NEG}
    );

    // zero target settles to decay on the following edge
    a_zero_decays: assert property (
        @(posedge clk) disable iff (!resetn)
        target_zero |=> (mode == MODE_DECAY)
    );

endmodule

// File: src/drive_pkg.sv
// drive package: bridge modes, dead time and chopper rate constants
package drive_pkg;

    // what one h-bridge is asked to do
    typedef enum logic [1:0] {
        MODE_DECAY = 2'd0,  // both low sides on, current coasts to zero
        MODE_POS   = 2'd1,  // drive current in the positive direction
        MODE_NEG   = 2'd2   // drive current in the negative direction
    } bridge_mode_t;

    localparam int DEAD_CYCLES = 3;   // all-off cycles on every mode change
    localparam int RAMP_DIV    = 2;   // cycles per count while the bridge drives
    localparam int DECAY_DIV   = 16;  // cycles per count in slow decay
    localparam int HYSTERESIS  = 4;   // chopper dead band in counts

    // counter widths sized from the rates above
    typedef logic [$clog2(DEAD_CYCLES + 1)-1:0] dead_cnt_t;
    typedef logic [$clog2(RAMP_DIV)-1:0]        ramp_cnt_t;
    typedef logic [$clog2(DECAY_DIV)-1:0]       decay_cnt_t;

endpackage

// File: src/hbridge_coil.sv
// h-bridge coil model integrating the coil current from the four gate levels
`timescale 1ns/1ps

module hbridge_coil (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      low_1,
    input  logic                      high_1,
    input  logic                      low_2,
    input  logic                      high_2,
    input  logic                      polarity_invert_config,
    output motor_pkg::coil_current_t  current,
    output logic                      current_sum_polarity  // 1 when current >= 0
);
    import motor_pkg::*;
    import drive_pkg::*;

    logic       on;          // a diagonal pair conducts
    logic       polarity;    // 1 when driving positive
    logic       slow_decay;  // both lows (or both highs) shorting the coil
    ramp_cnt_t  ramp_cnt;    // free-running ramp divider
    decay_cnt_t decay_cnt;   // free-running decay divider
    logic       ramp_tick;
    logic       decay_tick;

    assign ramp_tick  = (ramp_cnt == '0);
    assign decay_tick = (decay_cnt == '0);
    assign current_sum_polarity = (current >= 0);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            current    <= '0;
            on         <= 1'b0;
            polarity   <= 1'b0;
            slow_decay <= 1'b0;
            ramp_cnt   <= '0;
            decay_cnt  <= '0;
        end else begin
            ramp_cnt  <= (ramp_cnt == ramp_cnt_t'(RAMP_DIV - 1)) ? '0 : ramp_cnt + 1'b1;
            decay_cnt <= (decay_cnt == decay_cnt_t'(DECAY_DIV - 1)) ? '0 : decay_cnt + 1'b1;
            // gates become bridge state one cycle later
            on <= (low_1 && high_2) || (low_2 && high_1);
            if (polarity_invert_config)
                polarity <= low_2 && high_1;  // swapped wiring
            else
                polarity <= low_1 && high_2;
            slow_decay <= (low_1 && low_2) || (high_1 && high_2);
            if (on) begin
                if (ramp_tick)
                    current <= polarity ? current + 1'b1 : current - 1'b1;
            end else if (slow_decay && current != '0 && decay_tick) begin
                if (current > 0)
                    current <= current - 1'b1;  // coast toward zero
                else
                    current <= current + 1'b1;
            end
            // an open bridge holds the current
        end
    end

    // current stays inside the model's range
    a_current_range: assert property (
        @(posedge clk) disable iff (!resetn)
        (current <= CURRENT_LIMIT) && (current >= -CURRENT_LIMIT)
    );

endmodule

// File: src/motor_pkg.sv
// motor package: coil current and microstep types, sine table for the phase sequencer
package motor_pkg;

    typedef logic signed [12:0] coil_current_t;  // modelled coil current in counts
    typedef logic signed [13:0] current_err_t;   // target minus current, one bit of headroom
    typedef logic [4:0]         phase_idx_t;     // microstep position, 32 per electrical cycle

    localparam int PHASE_STEPS  = 32;   // table entries per electrical cycle
    localparam int PEAK_CURRENT = 400;  // target amplitude in counts

    // a quarter cycle ahead turns the sine into the cosine for coil b
    localparam phase_idx_t COS_OFFSET = phase_idx_t'(PHASE_STEPS / 4);

    // widest current the model may legally reach
    localparam coil_current_t CURRENT_LIMIT = 13'sd4095;

    // PEAK_CURRENT * sin(2*pi*k/32), rounded to the nearest count
    localparam coil_current_t SINE_TABLE [PHASE_STEPS] = '{
        0,                              // k = 0
        78,    153,   222,   283,       // rising first quarter
        333,   370,   392,
        400,                            // k = 8, positive peak
        392,   370,   333,   283,
        222,   153,   78,
        0,                              // k = 16, zero crossing
        -78,   -153,  -222,  -283,
        -333,  -370,  -392,
        -400,                           // k = 24, negative peak
        -392,  -370,  -333,  -283,
        -222,  -153,  -78
    };

endpackage

// File: src/step_sequencer.sv
// step sequencer counting microsteps and looking up sine/cosine current targets for both coils
`timescale 1ns/1ps

module step_sequencer (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      step,      // one-cycle pulse per microstep
    input  logic                      dir,       // 1 counts up, 0 counts down
    input  logic                      enable,
    output motor_pkg::phase_idx_t     phase_idx,
    output motor_pkg::coil_current_t  target_a,  // sine of the phase
    output motor_pkg::coil_current_t  target_b   // cosine of the phase
);
    import motor_pkg::*;

    phase_idx_t idx_b;  // coil b looks a quarter cycle ahead

    assign idx_b = phase_idx + COS_OFFSET;  // wraps modulo 32 in 5 bits

    // phase counter drops steps while disabled
    always_ff @(posedge clk) begin
        if (!resetn) begin
            phase_idx <= '0;
        end else if (step && enable) begin
            if (dir)
                phase_idx <= phase_idx + 1'b1;
            else
                phase_idx <= phase_idx - 1'b1;
        end
    end

    // table lookup one cycle behind the index
    always_ff @(posedge clk) begin
        if (!resetn) begin
            target_a <= '0;
            target_b <= '0;
        end else if (!enable) begin
            target_a <= '0;  // zero target makes both choppers decay
            target_b <= '0;
        end else begin
            target_a <= SINE_TABLE[phase_idx];
            target_b <= SINE_TABLE[idx_b];
        end
    end

endmodule

// File: src/stepper_drive.sv
// stepper drive top: sequencer, two choppers, two gate controllers and two coil models
`timescale 1ns/1ps

module stepper_drive (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      step,
    input  logic                      dir,
    input  logic                      enable,
    input  logic                      polarity_invert_config,
    output motor_pkg::phase_idx_t     phase_idx,
    output logic                      gate_a_low_1,
    output logic                      gate_a_high_1,
    output logic                      gate_a_low_2,
    output logic                      gate_a_high_2,
    output logic                      gate_b_low_1,
    output logic                      gate_b_high_1,
    output logic                      gate_b_low_2,
    output logic                      gate_b_high_2,
    output motor_pkg::coil_current_t  current_a,
    output motor_pkg::coil_current_t  current_b
);
    import motor_pkg::*;
    import drive_pkg::*;

    coil_current_t target_a;   // sine target
    coil_current_t target_b;   // cosine target
    bridge_mode_t  mode_a;
    bridge_mode_t  mode_b;
    logic          positive_a; // coil sign back to its chopper
    logic          positive_b;

    step_sequencer sequencer (
        .clk(clk), .resetn(resetn), .step(step), .dir(dir), .enable(enable),
        .phase_idx(phase_idx), .target_a(target_a), .target_b(target_b)
    );

    current_chopper chopper_a (
        .clk(clk), .resetn(resetn), .target(target_a), .current(current_a),
        .current_positive(positive_a), .mode(mode_a)
    );

    current_chopper chopper_b (
        .clk(clk), .resetn(resetn), .target(target_b), .current(current_b),
        .current_positive(positive_b), .mode(mode_b)
    );

    bridge_gate_ctrl gate_ctrl_a (
        .clk(clk), .resetn(resetn), .mode(mode_a),
        .polarity_invert_config(polarity_invert_config),
        .low_1(gate_a_low_1), .high_1(gate_a_high_1),
        .low_2(gate_a_low_2), .high_2(gate_a_high_2)
    );

    bridge_gate_ctrl gate_ctrl_b (
        .clk(clk), .resetn(resetn), .mode(mode_b),
        .polarity_invert_config(polarity_invert_config),
        .low_1(gate_b_low_1), .high_1(gate_b_high_1),
        .low_2(gate_b_low_2), .high_2(gate_b_high_2)
    );

    // coil models close the loop, current and sign go back to the choppers
    hbridge_coil coil_a (
        .clk(clk), .resetn(resetn),
        .low_1(gate_a_low_1), .high_1(gate_a_high_1),
        .low_2(gate_a_low_2), .high_2(gate_a_high_2),
        .polarity_invert_config(polarity_invert_config),
        .current(current_a), .current_sum_polarity(positive_a)
    );

    hbridge_coil coil_b (
        .clk(clk), .resetn(resetn),
        .low_1(gate_b_low_1), .high_1(gate_b_high_1),
        .low_2(gate_b_low_2), .high_2(gate_b_high_2),
        .polarity_invert_config(polarity_invert_config),
        .current(current_b), .current_sum_polarity(positive_b)
    );

endmodule

// File: testbench/tb_stepper_drive.sv
// stepper drive testbench: table of step rows with phase, coil current and gate pattern checks
`timescale 1ns/1ps

module tb_stepper_drive;
    import motor_pkg::*;
    import drive_pkg::*;

    localparam int NUM_FIXED    = 10;                             // hand-written rows
    localparam int NUM_ROWS     = 14;                             // plus a random tail
    localparam int IDLE_CYCLES  = 20;                             // disabled window after reset
    localparam int TOL          = HYSTERESIS + 2;                 // allowed distance from table
    localparam int RAMP_SETTLE  = 2 * RAMP_DIV * PEAK_CURRENT + 200;  // full swing while driving
    localparam int DECAY_SETTLE = PEAK_CURRENT * DECAY_DIV + 600;     // peak coasting to zero

    logic          clk;
    logic          resetn;
    logic          step;
    logic          dir;
    logic          enable;
    logic          polarity_invert_config;
    phase_idx_t    phase_idx;
    logic          gate_a_low_1, gate_a_high_1, gate_a_low_2, gate_a_high_2;
    logic          gate_b_low_1, gate_b_high_1, gate_b_low_2, gate_b_high_2;
    coil_current_t current_a;
    coil_current_t current_b;

    logic [3:0]    gates_a;  // {high_2, low_2, high_1, low_1}
    logic [3:0]    gates_b;
    logic [7:0]    all_gates;

    // stimulus table, one entry per row
    int            row_steps  [NUM_ROWS];
    bit            row_dir    [NUM_ROWS];
    bit            row_en     [NUM_ROWS];
    bit            row_inv    [NUM_ROWS];
    int            row_settle [NUM_ROWS];

    int            seed = 65213;
    int            exp_idx;      // own count of applied steps, modulo 32
    int unsigned   cycle_cnt;
    int unsigned   cycle_limit;

    // per coil history for the gate and current monitor
    logic [3:0]    last_active [2];  // last non-zero gate pattern
    int            zero_run    [2];  // all-low samples since then
    logic [3:0]    gates_d1    [2];
    logic [3:0]    gates_d2    [2];
    logic          inv_d1      [2];
    logic          inv_d2      [2];
    int            cur_d1      [2];

    assign gates_a   = {gate_a_high_2, gate_a_low_2, gate_a_high_1, gate_a_low_1};
    assign gates_b   = {gate_b_high_2, gate_b_low_2, gate_b_high_1, gate_b_low_1};
    assign all_gates = {gates_b, gates_a};

    stepper_drive dut0 (
        .clk(clk), .resetn(resetn), .step(step), .dir(dir), .enable(enable),
        .polarity_invert_config(polarity_invert_config), .phase_idx(phase_idx),
        .gate_a_low_1(gate_a_low_1), .gate_a_high_1(gate_a_high_1),
        .gate_a_low_2(gate_a_low_2), .gate_a_high_2(gate_a_high_2),
        .gate_b_low_1(gate_b_low_1), .gate_b_high_1(gate_b_high_1),
        .gate_b_low_2(gate_b_low_2), .gate_b_high_2(gate_b_high_2),
        .current_a(current_a), .current_b(current_b)
    );

    always #5 clk = ~clk;  // 10 ns period

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first failure");
    endtask

    // inputs change a little after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic set_row(input int i, input int steps, input bit up, input bit en,
                           input bit inv, input int settle);
        row_steps[i]  = steps;
        row_dir[i]    = up;
        row_en[i]     = en;
        row_inv[i]    = inv;
        row_settle[i] = settle;
    endtask

    task automatic fill_table();
        int steps;
        bit up;
        set_row(0, 0,  1'b1, 1'b1, 1'b0, RAMP_SETTLE);   // coil b climbs to the cosine peak
        set_row(1, 4,  1'b1, 1'b1, 1'b0, RAMP_SETTLE);
        set_row(2, 4,  1'b1, 1'b1, 1'b0, DECAY_SETTLE);  // index 8, coil b target zero
        set_row(3, 3,  1'b0, 1'b1, 1'b0, RAMP_SETTLE);
        set_row(4, 12, 1'b0, 1'b1, 1'b0, RAMP_SETTLE);   // wraps below zero, coil a swings negative
        set_row(5, 6,  1'b1, 1'b0, 1'b0, DECAY_SETTLE);  // steps ignored while disabled
        set_row(6, 0,  1'b1, 1'b1, 1'b1, RAMP_SETTLE);   // swapped wiring
        set_row(7, 9,  1'b1, 1'b1, 1'b1, RAMP_SETTLE);
        set_row(8, 2,  1'b0, 1'b0, 1'b1, DECAY_SETTLE);
        set_row(9, 0,  1'b1, 1'b1, 1'b0, RAMP_SETTLE);   // back to normal wiring
        for (int i = NUM_FIXED; i < NUM_ROWS; i++) begin
            steps = $unsigned($random(seed)) % PHASE_STEPS;
            up    = ($random(seed) & 1) != 0;
            set_row(i, steps, up, 1'b1, 1'b0, DECAY_SETTLE);  // target may land on zero
        end
    endtask

    // reset, idle window and every row, one cycle per step edge
    function automatic int run_length();
        int total;
        total = 3 + IDLE_CYCLES;
        for (int r = 0; r < NUM_ROWS; r++)
            total += 2 * row_steps[r] + row_settle[r];
        return total;
    endfunction

    function automatic bit same_sign(input int got, input int expected);
        if (expected > 0)
            return got > 0;
        else if (expected < 0)
            return got < 0;
        return 1'b1;  // zero target, the band alone decides
    endfunction

    // legal current change under the gates seen two samples earlier
    function automatic bit step_allowed(input logic [3:0] g, input logic inv,
                                        input int prev, input int delta);
        logic drive_up;
        logic drive_down;
        logic coast;
        drive_up   = inv ? (g[2] & g[1]) : (g[0] & g[3]);  // low_1 with high_2 unless swapped
        drive_down = inv ? (g[0] & g[3]) : (g[2] & g[1]);
        coast      = (g[0] & g[2]) | (g[1] & g[3]);
        if (drive_up)
            return (delta == 0) || (delta == 1);
        if (drive_down)
            return (delta == 0) || (delta == -1);
        if (coast)
            return (delta == 0) || (prev > 0 && delta == -1) || (prev < 0 && delta == 1);
        return delta == 0;  // open bridge holds
    endfunction

    task automatic check_equal(input string name, input int got, input int expected);
        assert (got == expected)
            else stop_with_failure($sformatf("error %s: got 0x%0h expected 0x%0h",
                                             name, got, expected));
    endtask

    task automatic check_near(input string name, input int got, input int expected);
        int diff;
        diff = got - expected;
        assert (diff <= TOL && diff >= -TOL && same_sign(got, expected))
            else stop_with_failure($sformatf("error %s: got 0x%04h expected 0x%04h +/- %0d",
                                             name, got[12:0], expected[12:0], TOL));
    endtask

    task automatic check_coil(input int c, input logic [3:0] g, input int cur);
        int    delta;
        string name;
        name  = (c == 0) ? "a" : "b";
        delta = cur - cur_d1[c];
        if (resetn) begin
            assert (!(g[0] && g[1]) && !(g[2] && g[3]))
                else stop_with_failure($sformatf("error gate_%s: shoot-through 0x%01h", name, g));
            if (g != 4'b0000 && last_active[c] != 4'b0000 && g != last_active[c]) begin
                assert (zero_run[c] >= DEAD_CYCLES)
                    else stop_with_failure($sformatf(
                        "error gate_%s: 0x%01h follows 0x%01h after 0x%0h all-low cycles",
                        name, g, last_active[c], zero_run[c]));
            end
            assert (step_allowed(gates_d2[c], inv_d2[c], cur_d1[c], delta))
                else stop_with_failure($sformatf(
                    "error current_%s: 0x%04h after 0x%04h under gates 0x%01h",
                    name, cur[12:0], cur_d1[c][12:0], gates_d2[c]));
        end
        if (g == 4'b0000) begin
            zero_run[c] = zero_run[c] + 1;
        end else begin
            last_active[c] = g;
            zero_run[c]    = 0;
        end
        gates_d2[c] = gates_d1[c];  // coil reacts two edges after the gates
        gates_d1[c] = g;
        inv_d2[c]   = inv_d1[c];
        inv_d1[c]   = polarity_invert_config;
        cur_d1[c]   = cur;
    endtask

    task automatic apply_step();
        step = 1'b1;
        if (enable)
            exp_idx = dir ? (exp_idx + 1) % PHASE_STEPS
                          : (exp_idx + PHASE_STEPS - 1) % PHASE_STEPS;
        next_cycle();
        step = 1'b0;
        next_cycle();
    endtask

    task automatic run_row(input int r);
        bit reached;
        reached                = 1'b0;
        enable                 = row_en[r];
        dir                    = row_dir[r];
        polarity_invert_config = row_inv[r];
        for (int s = 0; s < row_steps[r]; s++)
            apply_step();
        for (int n = 0; n < row_settle[r]; n++) begin
            next_cycle();
            if (!row_en[r]) begin
                if (reached) begin
                    assert (current_a == 0 && current_b == 0)
                        else stop_with_failure($sformatf(
                            "error current_a/current_b: 0x%04h/0x%04h left zero",
                            current_a, current_b));
                end
                reached = reached || (current_a == 0 && current_b == 0);
            end
        end
        check_equal("phase_idx", phase_idx, exp_idx);
        if (row_en[r]) begin
            check_near("current_a", current_a, SINE_TABLE[exp_idx]);
            check_near("current_b", current_b,
                       SINE_TABLE[(exp_idx + PHASE_STEPS / 4) % PHASE_STEPS]);
        end else begin
            assert (reached)
                else stop_with_failure("coil currents did not decay to zero while disabled");
        end
    endtask

    always @(negedge clk) begin  // outputs settled mid cycle
        check_coil(0, gates_a, current_a);
        check_coil(1, gates_b, current_b);
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit)
            stop_with_failure($sformatf("timeout: run still busy after %0d cycles", cycle_limit));
    end

    initial begin
        clk                    = 1'b0;
        resetn                 = 1'b0;
        step                   = 1'b0;
        dir                    = 1'b1;
        enable                 = 1'b0;
        polarity_invert_config = 1'b0;
        exp_idx                = 0;
        cycle_cnt              = 0;
        for (int c = 0; c < 2; c++) begin
            last_active[c] = 4'b0000;
            zero_run[c]    = DEAD_CYCLES;
            gates_d1[c]    = 4'b0000;
            gates_d2[c]    = 4'b0000;
            inv_d1[c]      = 1'b0;
            inv_d2[c]      = 1'b0;
            cur_d1[c]      = 0;
        end
        fill_table();
        cycle_limit = run_length() * 6 / 5;  // 20% margin over the planned run
        repeat (3) @(posedge clk);
        #1 resetn = 1'b1;
        // disabled after reset, bridges stay open and coils empty
        repeat (IDLE_CYCLES) begin
            next_cycle();
            check_equal("all_gates", all_gates, 0);
            check_equal("current_a", current_a, 0);
            check_equal("current_b", current_b, 0);
        end
        for (int r = 0; r < NUM_ROWS; r++)
            run_row(r);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule
